// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_viterbi_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: src/decoded_buffer.sv
module decoded_buffer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          wr_i,
   input  logic [viterbi_pkg::IDX_W-1:0] wr_idx_i,
   input  logic                          wr_bit_i,
   input  logic                          shift_i,
   output logic                          bit_o
);

   import viterbi_pkg::*;

   logic [FRAME_LEN-1:0] bits_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         bits_q <= '0;
      else if (wr_i)
      begin
         // Traceback fills from the last bit down to bit 0
         for (int i = 0; i < FRAME_LEN; i++)
         begin
            if (wr_idx_i == IDX_W'(i))
               bits_q[i] <= wr_bit_i;
         end
      end
      else if (shift_i)
         bits_q <= {1'b0, bits_q[FRAME_LEN-1:1]};
   end

   // Bit 0 leaves first, so data comes out in input order
   assign bit_o = bits_q[0];

   // Tail positions are never stored, the controller gates them out
   assert property (@(posedge clk) disable iff (!rst)
      wr_i |-> (wr_idx_i < IDX_W'(FRAME_LEN)))
      else $error("decoded_buffer: write index %0d outside frame", wr_idx_i);

endmodule

// File: src/decoder_ctrl.sv
module decoder_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic sym_valid_i,
   output logic sym_ready_o,
   input  logic out_ready_i,
   output logic out_valid_o,
   output logic acs_en_o,
   output logic pm_clear_o,
   output logic count_up_o,
   output logic count_down_o,
   output logic count_load_o,
   output logic tb_start_o,
   output logic tb_update_o,
   output logic buf_wr_o,
   output logic buf_shift_o,
   input  logic at_top_i,
   input  logic at_zero_i,
   input  logic in_frame_i,
   input  logic at_frame_end_i
);

   import viterbi_pkg::*;

   phase_e phase_q;
   logic   trace_upd_q;
   logic   sym_take;
   logic   out_take;

   assign sym_ready_o = phase_q == PH_ACS;
   assign out_valid_o = phase_q == PH_EMIT;
   assign sym_take    = sym_valid_i && sym_ready_o;
   assign out_take    = out_valid_o && out_ready_i;

   // ACS steps once per accepted symbol
   assign acs_en_o     = sym_take;
   assign count_load_o = sym_take && at_top_i;
   assign tb_start_o   = sym_take && at_top_i;

   // Trace alternates address and update cycles
   assign tb_update_o  = (phase_q == PH_TRACE) && trace_upd_q;
   assign count_down_o = tb_update_o && !at_zero_i;
   assign buf_wr_o     = tb_update_o && in_frame_i;

   // Counter is reused to count bits on the way out
   assign count_up_o  = (sym_take && !at_top_i) || out_take;
   assign buf_shift_o = out_take;
   assign pm_clear_o  = out_take && at_frame_end_i;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         phase_q     <= PH_ACS;
         trace_upd_q <= 1'b0;
      end
      else
      begin
         case (phase_q)
            PH_ACS:
            begin
               trace_upd_q <= 1'b0;
               if (count_load_o)
                  phase_q <= PH_TRACE;
            end
            PH_TRACE:
            begin
               trace_upd_q <= !trace_upd_q;
               // Step at index 0 is the last one
               if (tb_update_o && at_zero_i)
                  phase_q <= PH_EMIT;
            end
            PH_EMIT:
            begin
               if (pm_clear_o)
                  phase_q <= PH_ACS;
            end
            default:
               phase_q <= PH_ACS;
         endcase
      end
   end

   // Input and output never overlap with one frame in flight
   assert property (@(posedge clk) disable iff (!rst) !(sym_ready_o && out_valid_o))
      else $error("decoder_ctrl: input and output open together");

endmodule

// File: src/path_metric_unit.sv
module path_metric_unit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   acs_en_i,
   input  logic                   clear_i,
   input  viterbi_pkg::symbol_t   sym_i,
   output viterbi_pkg::decision_t decision_o
);

   import viterbi_pkg::*;

   logic [METRIC_W-1:0]   metric_q [NUM_STATES];
   logic [METRIC_W-1:0]   metric_d [NUM_STATES];
   logic [NUM_STATES-1:0] valid_q;
   logic [NUM_STATES-1:0] valid_d;
   logic [NUM_STATES-1:0] top_bits;
   logic                  normalize;

   // Hamming distance from the received symbol to the label of branch {d, s}
   function automatic logic [1:0] branch_metric(input logic [STATE_W:0] window,
                                                input symbol_t        sym);
      logic c0;
      logic c1;
      c0 = ^(window & POLY_0);
      c1 = ^(window & POLY_1);
      return {1'b0, c0 ^ sym.c0} + {1'b0, c1 ^ sym.c1};
   endfunction

   for (genvar s = 0; s < NUM_STATES; s++)
   begin : g_acs
      // Predecessors differ only in the oldest bit
      localparam int                 P0 = s / 2;
      localparam int                 P1 = s / 2 + NUM_STATES / 2;
      localparam logic [STATE_W-1:0] ST = STATE_W'(s);

      logic [METRIC_W-1:0] sum_0;
      logic [METRIC_W-1:0] sum_1;
      logic                pick_1;

      always_comb
      begin
         sum_0  = metric_q[P0] + METRIC_W'(branch_metric({1'b0, ST}, sym_i));
         sum_1  = metric_q[P1] + METRIC_W'(branch_metric({1'b1, ST}, sym_i));
         // Ties stay on the predecessor with oldest bit 0
         pick_1 = valid_q[P1] && (!valid_q[P0] || (sum_1 < sum_0));
      end

      assign decision_o[s] = pick_1;
      assign valid_d[s]    = valid_q[P0] | valid_q[P1];
      assign metric_d[s]   = pick_1 ? sum_1 : sum_0;
      assign top_bits[s]   = metric_q[s][METRIC_W-1];
   end

   // All metrics past half range, so drop the top bit everywhere
   assign normalize = &top_bits;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         valid_q <= NUM_STATES'(1);
         for (int i = 0; i < NUM_STATES; i++)
            metric_q[i] <= '0;
      end
      else if (clear_i)
      begin
         valid_q <= NUM_STATES'(1);
         for (int i = 0; i < NUM_STATES; i++)
            metric_q[i] <= '0;
      end
      else if (acs_en_i)
      begin
         valid_q <= valid_d;
         for (int i = 0; i < NUM_STATES; i++)
         begin
            if (normalize)
               metric_q[i] <= {1'b0, metric_d[i][METRIC_W-2:0]};
            else
               metric_q[i] <= metric_d[i];
         end
      end
   end

   // Some path always survives, across frames and clears
   assert property (@(posedge clk) disable iff (!rst) valid_q != '0)
      else $error("path_metric_unit: no valid state left");

endmodule

// File: src/step_counter.sv
module step_counter (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          up_i,
   input  logic                          down_i,
   input  logic                          load_i,
   input  logic                          clear_i,
   output logic [viterbi_pkg::IDX_W-1:0] count_o,
   output logic                          at_top_o,
   output logic                          at_zero_o,
   output logic                          in_frame_o,
   output logic                          at_frame_end_o
);

   import viterbi_pkg::*;

   logic [IDX_W-1:0] count_q;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         count_q <= '0;
      else if (clear_i)
         count_q <= '0;
      else if (load_i)
         count_q <= IDX_W'(BLOCK_LEN - 1);
      else if (up_i)
         count_q <= count_q + 1'b1;
      else if (down_i)
         count_q <= count_q - 1'b1;
   end

   assign count_o        = count_q;
   assign at_top_o       = count_q == IDX_W'(BLOCK_LEN - 1);
   assign at_zero_o      = count_q == '0;
   assign in_frame_o     = count_q < IDX_W'(FRAME_LEN);
   assign at_frame_end_o = count_q == IDX_W'(FRAME_LEN - 1);

   assert property (@(posedge clk) disable iff (!rst) !(up_i && down_i))
      else $error("step_counter: up and down requested together");

endmodule

// File: src/survivor_mem.sv
module survivor_mem (
   input  logic                          clk,
   input  logic                          wr_i,
   input  logic [viterbi_pkg::IDX_W-1:0] addr_i,
   input  viterbi_pkg::decision_t        data_i,
   output viterbi_pkg::decision_t        data_o
);

   import viterbi_pkg::*;

   // One row of decisions per symbol of the frame
   decision_t mem [BLOCK_LEN];

   always_ff @(posedge clk)
   begin
      if (wr_i)
         mem[addr_i] <= data_i;
      // Read data shows up one cycle after the address
      data_o <= mem[addr_i];
   end

   // The counter never writes past the frame
   assert property (@(posedge clk) wr_i |-> (addr_i < IDX_W'(BLOCK_LEN)))
      else $error("survivor_mem: write address %0d out of range", addr_i);

endmodule

// File: src/traceback_unit.sv
module traceback_unit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start_i,
   input  logic                   update_i,
   input  viterbi_pkg::decision_t decision_i,
   output logic                   bit_o
);

   import viterbi_pkg::*;

   logic [STATE_W-1:0] state_q;
   logic               pred_bit;

   // Oldest bit of the winning predecessor of the current state
   assign pred_bit = decision_i[state_q];

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         state_q <= '0;
      else if (start_i)
         // Terminated frame ends in state 0
         state_q <= '0;
      else if (update_i)
         state_q <= {pred_bit, state_q[STATE_W-1:1]};
   end

   // Newest bit of a state is the data bit that led into it
   assign bit_o = state_q[0];

endmodule

// File: src/viterbi_pkg.sv
package viterbi_pkg;

   // Code and trellis
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = $clog2(NUM_STATES);

   // Taps over the window {oldest state bit .. newest input bit}
   localparam logic [3:0] POLY_0 = 4'o15;
   localparam logic [3:0] POLY_1 = 4'o17;

   // Frame layout
   localparam int FRAME_LEN = 32;
   localparam int TAIL_LEN  = 3;
   localparam int BLOCK_LEN = FRAME_LEN + TAIL_LEN;

   localparam int IDX_W    = 6;
   localparam int METRIC_W = 8;

   // c0 sits in bit 0
   typedef struct packed {
      logic c1;
      logic c0;
   } symbol_t;

   // One survivor choice per state, bit s for state s
   typedef logic [NUM_STATES-1:0] decision_t;

   typedef enum logic [1:0] {
      PH_ACS,
      PH_TRACE,
      PH_EMIT
   } phase_e;

endpackage

// File: src/viterbi_top.sv
module viterbi_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 sym_valid_i,
   input  viterbi_pkg::symbol_t sym_i,
   output logic                 sym_ready_o,
   output logic                 out_valid_o,
   input  logic                 out_ready_i,
   output logic                 out_bit_o
);

   import viterbi_pkg::*;

   logic             acs_en;
   logic             pm_clear;
   logic             count_up;
   logic             count_down;
   logic             count_load;
   logic             tb_start;
   logic             tb_update;
   logic             buf_wr;
   logic             buf_shift;
   logic [IDX_W-1:0] count;
   logic             at_top;
   logic             at_zero;
   logic             in_frame;
   logic             at_frame_end;
   decision_t        acs_decision;
   decision_t        rd_decision;
   logic             tb_bit;

   decoder_ctrl u_decoder_ctrl (
      .clk            (clk),
      .rst            (rst),
      .sym_valid_i    (sym_valid_i),
      .sym_ready_o    (sym_ready_o),
      .out_ready_i    (out_ready_i),
      .out_valid_o    (out_valid_o),
      .acs_en_o       (acs_en),
      .pm_clear_o     (pm_clear),
      .count_up_o     (count_up),
      .count_down_o   (count_down),
      .count_load_o   (count_load),
      .tb_start_o     (tb_start),
      .tb_update_o    (tb_update),
      .buf_wr_o       (buf_wr),
      .buf_shift_o    (buf_shift),
      .at_top_i       (at_top),
      .at_zero_i      (at_zero),
      .in_frame_i     (in_frame),
      .at_frame_end_i (at_frame_end)
   );

   step_counter u_step_counter (
      .clk            (clk),
      .rst            (rst),
      .up_i           (count_up),
      .down_i         (count_down),
      .load_i         (count_load),
      .clear_i        (pm_clear),
      .count_o        (count),
      .at_top_o       (at_top),
      .at_zero_o      (at_zero),
      .in_frame_o     (in_frame),
      .at_frame_end_o (at_frame_end)
   );

   path_metric_unit u_path_metric_unit (
      .clk        (clk),
      .rst        (rst),
      .acs_en_i   (acs_en),
      .clear_i    (pm_clear),
      .sym_i      (sym_i),
      .decision_o (acs_decision)
   );

   // Decisions land in the same cycle the symbol is taken
   survivor_mem u_survivor_mem (
      .clk    (clk),
      .wr_i   (acs_en),
      .addr_i (count),
      .data_i (acs_decision),
      .data_o (rd_decision)
   );

   traceback_unit u_traceback_unit (
      .clk        (clk),
      .rst        (rst),
      .start_i    (tb_start),
      .update_i   (tb_update),
      .decision_i (rd_decision),
      .bit_o      (tb_bit)
   );

   decoded_buffer u_decoded_buffer (
      .clk      (clk),
      .rst      (rst),
      .wr_i     (buf_wr),
      .wr_idx_i (count),
      .wr_bit_i (tb_bit),
      .shift_i  (buf_shift),
      .bit_o    (out_bit_o)
   );

endmodule

// File: verification/tb_viterbi_top.sv
module tb_viterbi_top;

   import viterbi_pkg::*;

   localparam int NUM_FRAMES = 20;
   localparam int TOTAL_BITS = NUM_FRAMES * FRAME_LEN;
   // Back-pressure from this frame on, source gaps from GAP_START on
   localparam int BP_START   = 5;
   localparam int GAP_START  = 10;
   localparam int READY_LEN  = 256;
   // Address and update cycle per step, plus the phase change
   localparam int LATENCY    = 2 * BLOCK_LEN + 1;
   // About 400 cycles per frame with margin
   localparam int MAX_CYCLES = NUM_FRAMES * 400 + 4000;

   logic    clk;
   logic    rst;
   logic    sym_valid_i;
   symbol_t sym_i;
   logic    sym_ready_o;
   logic    out_valid_o;
   logic    out_ready_i;
   logic    out_bit_o;
   logic    sym_take;
   logic    out_take;

   int      seed;
   symbol_t sym_q[$];
   int      gap_q[$];
   bit      exp_q[$];
   bit      ready_q[$];
   int      ready_pos;

   int      cycles;
   int      sym_cnt;
   int      wait_cnt;
   int      out_cnt;
   int      frame_bits;
   bit      exp_bit;
   bit      hold_pending;
   bit      held_bit;

   viterbi_top u_viterbi_top (
      .clk         (clk),
      .rst         (rst),
      .sym_valid_i (sym_valid_i),
      .sym_i       (sym_i),
      .sym_ready_o (sym_ready_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_bit_o   (out_bit_o)
   );

   assign sym_take = sym_valid_i && sym_ready_o;
   assign out_take = out_valid_o && out_ready_i;

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_error(input string msg);
      $display("Errors found");
      $display("%s", msg);
      $fatal(1);
   endtask

   // Reference encoder, window is {state, newest bit}
   function automatic symbol_t encode_step(input logic [STATE_W-1:0] state, input logic b);
      logic [3:0] window;
      symbol_t    s;
      window = {state, b};
      s.c0   = ^(window & POLY_0);
      s.c1   = ^(window & POLY_1);
      return s;
   endfunction

   task automatic build_frames();
      logic [STATE_W-1:0] state;
      logic               b;
      symbol_t            s;
      int                 flip_pos;
      for (int f = 0; f < NUM_FRAMES; f++)
      begin
         state    = '0;
         flip_pos = -1;
         // Odd frames carry one channel error in the data part
         if (f % 2 == 1)
            flip_pos = $random(seed) & (FRAME_LEN - 1);
         for (int k = 0; k < BLOCK_LEN; k++)
         begin
            if (k < FRAME_LEN)
               b = 1'($random(seed));
            else
               b = 1'b0;
            s = encode_step(state, b);
            if (k == flip_pos)
            begin
               if (($random(seed) & 1) != 0)
                  s.c1 = !s.c1;
               else
                  s.c0 = !s.c0;
            end
            state = {state[STATE_W-2:0], b};
            if (k < FRAME_LEN)
               exp_q.push_back(b);
            sym_q.push_back(s);
            gap_q.push_back((f >= GAP_START) ? ($random(seed) & 3) : 0);
         end
      end
      for (int i = 0; i < READY_LEN; i++)
         ready_q.push_back(($random(seed) & 3) != 0);
   endtask

   task automatic send_symbol(input symbol_t s, input int gap);
      logic taken;
      repeat (gap)
      begin
         sym_valid_i = 1'b0;
         @(negedge clk);
      end
      sym_valid_i = 1'b1;
      sym_i       = s;
      taken       = 1'b0;
      // Ready is stable through the low half of the clock
      while (!taken)
      begin
         taken = sym_ready_o;
         @(negedge clk);
      end
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
         report_error("Timeout: the decoder did not finish all frames in time");
      if (!rst)
         exp_bit <= exp_q[0];
      else
      begin
         if (sym_take)
            sym_cnt <= (sym_cnt == BLOCK_LEN - 1) ? 0 : sym_cnt + 1;
         if (sym_take && sym_cnt == BLOCK_LEN - 1)
            wait_cnt <= 1;
         else if (wait_cnt != 0 && !out_valid_o)
            wait_cnt <= wait_cnt + 1;
         if (out_take)
         begin
            out_cnt    <= out_cnt + 1;
            frame_bits <= frame_bits + 1;
            if (out_cnt + 1 < TOTAL_BITS)
               exp_bit <= exp_q[out_cnt + 1];
         end
         else if (!out_valid_o)
            frame_bits <= 0;
         hold_pending <= out_valid_o && !out_ready_i;
         held_bit     <= out_bit_o;
      end
   end

   reset_state: assert property (@(posedge clk) $rose(rst) |-> sym_ready_o && !out_valid_o)
      else report_error("Wrong handshake state right after reset");

   no_overlap: assert property (@(posedge clk) disable iff (!rst)
      !(sym_ready_o && out_valid_o))
      else report_error("sym_ready_o and out_valid_o were high together");

   no_extra_bit: assert property (@(posedge clk) disable iff (!rst)
      out_take |-> out_cnt < TOTAL_BITS)
      else report_error("Decoder sent more bits than the frames hold");

   bit_match: assert property (@(posedge clk) disable iff (!rst)
      out_take |-> out_bit_o == exp_bit)
      else report_error($sformatf("FAILED out_bit_o: got %0h expected %0h",
                                  $sampled(out_bit_o), $sampled(exp_bit)));

   hold_valid: assert property (@(posedge clk) disable iff (!rst)
      hold_pending |-> out_valid_o)
      else report_error("out_valid_o dropped before the bit was taken");

   hold_bit: assert property (@(posedge clk) disable iff (!rst)
      hold_pending |-> out_bit_o == held_bit)
      else report_error($sformatf("FAILED out_bit_o: got %0h expected %0h",
                                  $sampled(out_bit_o), $sampled(held_bit)));

   frame_length: assert property (@(posedge clk) disable iff (!rst)
      $fell(out_valid_o) |-> frame_bits == FRAME_LEN)
      else report_error($sformatf("FAILED frame_bits: got %0h expected %0h",
                                  $sampled(frame_bits), FRAME_LEN));

   latency: assert property (@(posedge clk) disable iff (!rst)
      $rose(out_valid_o) |-> wait_cnt == LATENCY)
      else report_error($sformatf("FAILED wait_cnt: got %0h expected %0h",
                                  $sampled(wait_cnt), LATENCY));

   initial
   begin
      out_ready_i = 1'b0;
      ready_pos   = 0;
      forever
      begin
         @(negedge clk);
         if (out_cnt < BP_START * FRAME_LEN)
            out_ready_i = 1'b1;
         else
         begin
            out_ready_i = ready_q[ready_pos];
            ready_pos   = (ready_pos + 1) % READY_LEN;
         end
      end
   end

   initial
   begin
      seed        = 32;
      rst         = 1'b0;
      sym_valid_i = 1'b0;
      sym_i       = '0;
      build_frames();
      repeat (5) @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < NUM_FRAMES * BLOCK_LEN; i++)
         send_symbol(sym_q[i], gap_q[i]);
      sym_valid_i = 1'b0;
      while (out_cnt < TOTAL_BITS)
         @(negedge clk);
      // Let the last frame's length check run
      repeat (2) @(negedge clk);
      if (out_cnt == TOTAL_BITS)
      begin
         $display("No errors");
         $finish;
      end
      else
         report_error("Number of decoded bits does not match the frames sent");
   end

endmodule

// File: vlog.f
src/viterbi_pkg.sv
src/path_metric_unit.sv
src/survivor_mem.sv
src/traceback_unit.sv
src/decoded_buffer.sv
src/step_counter.sv
src/decoder_ctrl.sv
src/viterbi_top.sv
verification/tb_viterbi_top.sv
